// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_unit_tb -f verilog.f -o exec_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/exec_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0

// ==== testbench/exec_unit_chk.sv ====
`timescale 1ns/1ps

module exec_unit_chk #(
    parameter int IQ_DEPTH    = 4,
    parameter int RES_CREDITS = 2
) (
    input logic              clk_i,
    input logic              reset_i,
    input logic              res_valid_i,
    input logic              res_credit_i,
    input logic              op_credit_i,
    input exec_pkg::credit_t iq_fill_i,
    input exec_pkg::credit_t res_credit_cnt_i
);

    exec_pkg::credit_t held_credits;

    // Credits the DUT holds, counted from its output handshake
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            held_credits <= exec_pkg::credit_t'(RES_CREDITS);
        end else if (res_credit_i && !res_valid_i) begin
            held_credits <= held_credits + 1'b1;
        end else if (!res_credit_i && res_valid_i) begin
            held_credits <= held_credits - 1'b1;
        end
    end

    // Both handshakes quiet in the cycle after reset
    assert property (@(posedge clk_i) reset_i |=> !res_valid_i && !op_credit_i)
        else $error("res_valid_o or op_credit_o high in the cycle after reset");

    // No result leaves without a downstream credit
    assert property (@(posedge clk_i) disable iff (reset_i)
                     res_valid_i |-> held_credits != '0)
        else $error("res_valid_o high with zero output credits");

    assert property (@(posedge clk_i) disable iff (reset_i)
                     iq_fill_i <= exec_pkg::credit_t'(IQ_DEPTH))
        else $error("issue queue fill count above its depth");

    assert property (@(posedge clk_i) disable iff (reset_i)
                     res_credit_cnt_i <= exec_pkg::credit_t'(RES_CREDITS))
        else $error("output credit count above its initial value");

endmodule

bind exec_unit exec_unit_chk #(
    .IQ_DEPTH    (IQ_DEPTH),
    .RES_CREDITS (RES_CREDITS)
) i_exec_unit_chk (
    .clk_i,
    .reset_i,
    .res_valid_i      (res_valid_o),
    .res_credit_i,
    .op_credit_i      (op_credit_o),
    .iq_fill_i        (i_issue_queue.fill_cnt),
    .res_credit_cnt_i (i_result_queue.credit_cnt)
);

// ==== testbench/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb;

    localparam int IQ_DEPTH    = 4;
    localparam int RQ_DEPTH    = 4;
    localparam int RES_CREDITS = 2;
    localparam int NUM_OPS     = 400;
    localparam int MAX_CYCLES  = 20000;

    // Operation mix, OP weighted up so the multiplies come often
    localparam logic [6:0] OPC_TBL [16] = '{
        rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP,
        rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP,
        rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_JAL,
        rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC,
        rv_isa_pkg::OPC_FENCE, rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_STORE,
        rv_isa_pkg::OPC_NOP
    };

    typedef struct packed {
        rv_isa_pkg::word_t    reg_wdata;
        logic                 wr_reg_en;
        rv_isa_pkg::reg_idx_t wr_reg_idx;
        logic                 jump;
        rv_isa_pkg::word_t    jump_addr;
        rv_isa_pkg::word_t    pc;
        logic                 load;
        logic                 wr_mem_en;
        rv_isa_pkg::word_t    mem_addr;
        exec_pkg::byte_idx_t  byte_idx;
        rv_isa_pkg::word_t    wr_mem_data;
    } result_t;

    logic                 clk_i;
    logic                 reset_i;
    logic                 op_valid_i;
    logic                 op_credit_o;
    logic                 res_valid_o;
    logic                 res_credit_i;
    rv_isa_pkg::inst_t    op_inst_i;
    rv_isa_pkg::word_t    op_pc_i, op1_i, op2_i, op1_jump_i, op2_jump_i, op_store_data_i;
    rv_isa_pkg::word_t    res_reg_wdata_o, res_jump_addr_o, res_pc_o, res_mem_addr_o;
    rv_isa_pkg::word_t    res_wr_mem_data_o;
    logic                 res_wr_reg_en_o, res_jump_o, res_load_o, res_wr_mem_en_o;
    rv_isa_pkg::reg_idx_t res_wr_reg_idx_o;
    exec_pkg::byte_idx_t  res_byte_idx_o;

    logic [31:0] lfsr;
    result_t     exp_q[$];
    int          sent;
    int          received;
    int          in_credits;
    int          out_credits;

    exec_unit #(
        .IQ_DEPTH    (IQ_DEPTH),
        .RQ_DEPTH    (RQ_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) i_exec_unit (.*);

    always #10 clk_i = ~clk_i;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic result_t model_result(input rv_isa_pkg::word_t pc,
                                             input rv_isa_pkg::inst_t inst,
                                             input rv_isa_pkg::word_t a,
                                             input rv_isa_pkg::word_t b,
                                             input rv_isa_pkg::word_t ja,
                                             input rv_isa_pkg::word_t jb,
                                             input rv_isa_pkg::word_t sd);
        result_t     r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  sh;
        logic [63:0] a64;
        logic [63:0] b64;
        logic [63:0] prod;
        logic        take;
        opc           = inst[6:0];
        f3            = inst[14:12];
        sh            = (opc == rv_isa_pkg::OPC_OP_IMM) ? inst[24:20] : b[4:0];
        r             = '0;
        r.pc          = pc;
        r.wr_reg_idx  = inst[11:7];
        r.mem_addr    = a + b;
        r.byte_idx    = r.mem_addr[1:0];
        r.wr_mem_data = sd;
        r.load        = (opc == rv_isa_pkg::OPC_LOAD);
        r.wr_mem_en   = (opc == rv_isa_pkg::OPC_STORE);
        r.wr_reg_en   = (inst[11:7] != 5'd0) && (opc inside {rv_isa_pkg::OPC_OP_IMM,
                        rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC,
                        rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_LOAD});
        if (opc == rv_isa_pkg::OPC_OP && inst[31:25] == rv_isa_pkg::F7_MULDIV) begin
            // Extend each operand by its own signedness, take the low 64 bits
            a64  = (f3 == rv_isa_pkg::F3_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
            b64  = (f3 inside {rv_isa_pkg::F3_MULHSU, rv_isa_pkg::F3_MULHU}) ?
                   {32'b0, b} : {{32{b[31]}}, b};
            prod = a64 * b64;
            if (f3 == rv_isa_pkg::F3_MUL) begin
                r.reg_wdata = prod[31:0];
            end else if (f3 inside {rv_isa_pkg::F3_MULH, rv_isa_pkg::F3_MULHSU,
                                    rv_isa_pkg::F3_MULHU}) begin
                r.reg_wdata = prod[63:32];
            end
        end else if (opc inside {rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP}) begin
            case (f3)
                rv_isa_pkg::F3_ADD_SUB: begin
                    r.reg_wdata = (opc == rv_isa_pkg::OPC_OP && inst[30]) ? a - b : a + b;
                end
                rv_isa_pkg::F3_SLL:  r.reg_wdata = a << sh;
                rv_isa_pkg::F3_SLT:  r.reg_wdata = {31'b0, $signed(a) < $signed(b)};
                rv_isa_pkg::F3_SLTU: r.reg_wdata = {31'b0, a < b};
                rv_isa_pkg::F3_XOR:  r.reg_wdata = a ^ b;
                rv_isa_pkg::F3_OR:   r.reg_wdata = a | b;
                rv_isa_pkg::F3_AND:  r.reg_wdata = a & b;
                default: begin
                    if (inst[30]) begin
                        r.reg_wdata = $signed(a) >>> sh;
                    end else begin
                        r.reg_wdata = a >> sh;
                    end
                end
            endcase
        end else if (opc == rv_isa_pkg::OPC_BRANCH) begin
            case (f3)
                rv_isa_pkg::F3_BEQ:  take = (a == b);
                rv_isa_pkg::F3_BNE:  take = (a != b);
                rv_isa_pkg::F3_BLT:  take = ($signed(a) < $signed(b));
                rv_isa_pkg::F3_BGE:  take = ($signed(a) >= $signed(b));
                rv_isa_pkg::F3_BLTU: take = (a < b);
                rv_isa_pkg::F3_BGEU: take = (a >= b);
                default:             take = 1'b0;
            endcase
            r.jump      = take;
            r.jump_addr = take ? ja + jb : '0;
        end else if (opc inside {rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR,
                                 rv_isa_pkg::OPC_FENCE}) begin
            r.jump      = 1'b1;
            r.jump_addr = ja + jb;
            if (opc != rv_isa_pkg::OPC_FENCE) begin
                r.reg_wdata = a + b;
            end
        end else if (opc inside {rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC}) begin
            r.reg_wdata = a + b;
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // Each op_credit_o pulse must belong to an operation still outstanding
    task automatic count_credit_pulse();
        assert (in_credits < IQ_DEPTH) else begin
            abort_run("op_credit_o pulsed with no operation outstanding");
        end
        in_credits++;
    endtask

    task automatic issue_op();
        rv_isa_pkg::inst_t inst;
        logic [1:0]        f7_sel;
        inst      = next_bits(32);
        inst[6:0] = OPC_TBL[4'(next_bits(4))];
        if (inst[6:0] == rv_isa_pkg::OPC_OP) begin
            f7_sel      = 2'(next_bits(2));
            inst[31:25] = (f7_sel == 2'd2) ? rv_isa_pkg::F7_BASE :
                          (f7_sel == 2'd3) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_MULDIV;
        end
        op_inst_i       = inst;
        op_pc_i         = 32'(sent) << 2;
        op1_i           = next_bits(32);
        // Equal operands now and then so equality branches are taken
        op2_i           = (next_bits(2) == 0) ? op1_i : next_bits(32);
        op1_jump_i      = next_bits(32);
        op2_jump_i      = next_bits(32);
        op_store_data_i = next_bits(32);
        op_valid_i      = 1'b1;
        exp_q.push_back(model_result(op_pc_i, inst, op1_i, op2_i, op1_jump_i, op2_jump_i,
                                     op_store_data_i));
        sent++;
        in_credits--;
    endtask

    task automatic check_result();
        result_t e;
        assert (exp_q.size() != 0) else begin
            abort_run("a result arrived with no operation in flight");
        end
        assert (out_credits > 0) else begin
            abort_run("a result arrived while the DUT held no output credit");
        end
        e = exp_q.pop_front();
        out_credits--;
        received++;
        check_field("res_pc_o", res_pc_o, e.pc);
        check_field("res_reg_wdata_o", res_reg_wdata_o, e.reg_wdata);
        check_field("res_wr_reg_en_o", 32'(res_wr_reg_en_o), 32'(e.wr_reg_en));
        check_field("res_wr_reg_idx_o", 32'(res_wr_reg_idx_o), 32'(e.wr_reg_idx));
        check_field("res_jump_o", 32'(res_jump_o), 32'(e.jump));
        check_field("res_jump_addr_o", res_jump_addr_o, e.jump_addr);
        check_field("res_load_o", 32'(res_load_o), 32'(e.load));
        check_field("res_wr_mem_en_o", 32'(res_wr_mem_en_o), 32'(e.wr_mem_en));
        check_field("res_mem_addr_o", res_mem_addr_o, e.mem_addr);
        check_field("res_byte_idx_o", 32'(res_byte_idx_o), 32'(e.byte_idx));
        check_field("res_wr_mem_data_o", res_wr_mem_data_o, e.wr_mem_data);
    endtask

    initial begin
        int   cycles;
        logic hold;
        clk_i           = 1'b0;
        reset_i         = 1'b1;
        op_valid_i      = 1'b0;
        op_pc_i         = '0;
        op_inst_i       = '0;
        op1_i           = '0;
        op2_i           = '0;
        op1_jump_i      = '0;
        op2_jump_i      = '0;
        op_store_data_i = '0;
        res_credit_i    = 1'b0;
        lfsr            = 32'hff0a;
        sent            = 0;
        received        = 0;
        in_credits      = IQ_DEPTH;
        out_credits     = RES_CREDITS;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        cycles = 0;
        while (received < NUM_OPS) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run($sformatf("timeout after %0d of %0d results", received, NUM_OPS));
            end
            if (op_credit_o) begin
                count_credit_pulse();
            end
            if (res_valid_o) begin
                check_result();
            end
            // Downstream stalls for the last quarter of every 256 cycles
            hold         = (cycles % 256) >= 192;
            res_credit_i = 1'b0;
            if (out_credits < RES_CREDITS && !hold && next_bits(2) == 0) begin
                res_credit_i = 1'b1;
                out_credits++;
            end
            op_valid_i = 1'b0;
            if (sent < NUM_OPS && in_credits > 0 && next_bits(1) == 1) begin
                issue_op();
            end
        end

        cycles = 0;
        while (in_credits < IQ_DEPTH) begin
            @(negedge clk_i);
            res_credit_i = 1'b0;
            cycles++;
            if (cycles > 100) begin
                abort_run("timeout waiting for the last op_credit_o pulses");
            end
            if (op_credit_o) begin
                count_credit_pulse();
            end
            if (res_valid_o) begin
                check_result();
            end
        end

        // A drained DUT stays silent on both handshakes
        for (int i = 0; i < IQ_DEPTH + RQ_DEPTH; i++) begin
            @(negedge clk_i);
            if (op_credit_o) begin
                count_credit_pulse();
            end
            if (res_valid_o) begin
                check_result();
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/rv_isa_pkg.sv
verilog/exec_pkg.sv
verilog/issue_queue.sv
verilog/alu.sv
verilog/result_queue.sv
verilog/exec_unit.sv
testbench/exec_unit_chk.sv
testbench/exec_unit_tb.sv

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  rv_isa_pkg::word_t    pc_i,
    input  rv_isa_pkg::inst_t    inst_i,
    input  rv_isa_pkg::word_t    op1_i,
    input  rv_isa_pkg::word_t    op2_i,
    input  rv_isa_pkg::word_t    op1_jump_i,
    input  rv_isa_pkg::word_t    op2_jump_i,
    input  rv_isa_pkg::word_t    store_data_i,
    output rv_isa_pkg::word_t    reg_wdata_o,
    output logic                 wr_reg_en_o,
    output rv_isa_pkg::reg_idx_t wr_reg_idx_o,
    output logic                 jump_o,
    output rv_isa_pkg::word_t    jump_addr_o,
    output rv_isa_pkg::word_t    pc_o,
    output logic                 load_o,
    output logic                 wr_mem_en_o,
    output rv_isa_pkg::word_t    mem_addr_o,
    output exec_pkg::byte_idx_t  byte_idx_o,
    output rv_isa_pkg::word_t    wr_mem_data_o
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    sum;
    rv_isa_pkg::word_t    target;
    logic                 lt_signed;
    logic                 lt_unsigned;
    logic [4:0]           shamt;
    rv_isa_pkg::word_t    shift_res;
    logic                 neg1;
    logic                 neg2;
    rv_isa_pkg::word_t    mag1;
    rv_isa_pkg::word_t    mag2;
    logic [63:0]          mag_prod;
    logic [63:0]          product;
    logic                 taken;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];

    assign sum         = op1_i + op2_i;
    assign target      = op1_jump_i + op2_jump_i;
    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;

    // Immediate shifts take shamt from the instruction
    assign shamt = (opcode == rv_isa_pkg::OPC_OP_IMM) ? inst_i[24:20] : op2_i[4:0];

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_SLL: shift_res = op1_i << shamt;
            default:            shift_res = inst_i[30] ? rv_isa_pkg::word_t'($signed(op1_i) >>> shamt)
                                                       : op1_i >> shamt;
        endcase
    end

    // Sign-magnitude multiply, MULHU treats both operands unsigned
    assign neg1     = op1_i[31] && (funct3 != rv_isa_pkg::F3_MULHU);
    assign neg2     = op2_i[31] && ((funct3 == rv_isa_pkg::F3_MUL) ||
                                    (funct3 == rv_isa_pkg::F3_MULH));
    assign mag1     = neg1 ? -op1_i : op1_i;
    assign mag2     = neg2 ? -op2_i : op2_i;
    assign mag_prod = {32'b0, mag1} * {32'b0, mag2};
    assign product  = (neg1 ^ neg2) ? -mag_prod : mag_prod;

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:  taken = (op1_i == op2_i);
            rv_isa_pkg::F3_BNE:  taken = (op1_i != op2_i);
            rv_isa_pkg::F3_BLT:  taken = lt_signed;
            rv_isa_pkg::F3_BGE:  taken = !lt_signed;
            rv_isa_pkg::F3_BLTU: taken = lt_unsigned;
            rv_isa_pkg::F3_BGEU: taken = !lt_unsigned;
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        reg_wdata_o = '0;
        jump_o      = 1'b0;
        jump_addr_o = '0;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
                if (opcode == rv_isa_pkg::OPC_OP && funct7 == rv_isa_pkg::F7_MULDIV) begin
                    // Division and remainder yield zero
                    case (funct3)
                        rv_isa_pkg::F3_MUL:    reg_wdata_o = product[31:0];
                        rv_isa_pkg::F3_MULH,
                        rv_isa_pkg::F3_MULHSU,
                        rv_isa_pkg::F3_MULHU:  reg_wdata_o = product[63:32];
                        default:               reg_wdata_o = '0;
                    endcase
                end else if (opcode == rv_isa_pkg::OPC_OP_IMM ||
                             funct7 == rv_isa_pkg::F7_BASE || funct7 == rv_isa_pkg::F7_ALT) begin
                    case (funct3)
                        rv_isa_pkg::F3_ADD_SUB: begin
                            reg_wdata_o = (opcode == rv_isa_pkg::OPC_OP && inst_i[30]) ?
                                          op1_i - op2_i : sum;
                        end
                        rv_isa_pkg::F3_SLL,
                        rv_isa_pkg::F3_SR:   reg_wdata_o = shift_res;
                        rv_isa_pkg::F3_SLT:  reg_wdata_o = {31'b0, lt_signed};
                        rv_isa_pkg::F3_SLTU: reg_wdata_o = {31'b0, lt_unsigned};
                        rv_isa_pkg::F3_XOR:  reg_wdata_o = op1_i ^ op2_i;
                        rv_isa_pkg::F3_OR:   reg_wdata_o = op1_i | op2_i;
                        default:             reg_wdata_o = op1_i & op2_i;
                    endcase
                end
            end
            rv_isa_pkg::OPC_BRANCH: begin
                jump_o      = taken;
                jump_addr_o = taken ? target : '0;
            end
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                reg_wdata_o = sum;
                jump_o      = 1'b1;
                jump_addr_o = target;
            end
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
                reg_wdata_o = sum;
            end
            rv_isa_pkg::OPC_FENCE: begin
                jump_o      = 1'b1;
                jump_addr_o = target;
            end
            default: begin
                reg_wdata_o = '0;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_LUI,
            rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR,
            rv_isa_pkg::OPC_LOAD: wr_reg_en_o = (rd != '0);
            default:              wr_reg_en_o = 1'b0;
        endcase
    end

    assign wr_reg_idx_o  = rd;
    assign pc_o          = pc_i;
    assign load_o        = (opcode == rv_isa_pkg::OPC_LOAD);
    assign wr_mem_en_o   = (opcode == rv_isa_pkg::OPC_STORE);
    assign mem_addr_o    = sum;
    assign byte_idx_o    = sum[1:0];
    assign wr_mem_data_o = store_data_i;

endmodule

// ==== verilog/exec_pkg.sv ====
package exec_pkg;

    // Byte position of a memory access inside its word
    typedef logic [1:0] byte_idx_t;

    // Credit or fill count, limits queue depth to 15
    typedef logic [3:0] credit_t;

endpackage

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit #(
    parameter int IQ_DEPTH    = 4,
    parameter int RQ_DEPTH    = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 op_valid_i,
    input  rv_isa_pkg::word_t    op_pc_i,
    input  rv_isa_pkg::inst_t    op_inst_i,
    input  rv_isa_pkg::word_t    op1_i,
    input  rv_isa_pkg::word_t    op2_i,
    input  rv_isa_pkg::word_t    op1_jump_i,
    input  rv_isa_pkg::word_t    op2_jump_i,
    input  rv_isa_pkg::word_t    op_store_data_i,
    output logic                 op_credit_o,
    output logic                 res_valid_o,
    output rv_isa_pkg::word_t    res_reg_wdata_o,
    output logic                 res_wr_reg_en_o,
    output rv_isa_pkg::reg_idx_t res_wr_reg_idx_o,
    output logic                 res_jump_o,
    output rv_isa_pkg::word_t    res_jump_addr_o,
    output rv_isa_pkg::word_t    res_pc_o,
    output logic                 res_load_o,
    output logic                 res_wr_mem_en_o,
    output rv_isa_pkg::word_t    res_mem_addr_o,
    output exec_pkg::byte_idx_t  res_byte_idx_o,
    output rv_isa_pkg::word_t    res_wr_mem_data_o,
    input  logic                 res_credit_i
);

    logic                 iq_valid;
    logic                 rq_ready;
    logic                 xfer;
    rv_isa_pkg::word_t    iq_pc;
    rv_isa_pkg::inst_t    iq_inst;
    rv_isa_pkg::word_t    iq_op1;
    rv_isa_pkg::word_t    iq_op2;
    rv_isa_pkg::word_t    iq_op1_jump;
    rv_isa_pkg::word_t    iq_op2_jump;
    rv_isa_pkg::word_t    iq_store_data;
    rv_isa_pkg::word_t    alu_reg_wdata;
    logic                 alu_wr_reg_en;
    rv_isa_pkg::reg_idx_t alu_wr_reg_idx;
    logic                 alu_jump;
    rv_isa_pkg::word_t    alu_jump_addr;
    rv_isa_pkg::word_t    alu_pc;
    logic                 alu_load;
    logic                 alu_wr_mem_en;
    rv_isa_pkg::word_t    alu_mem_addr;
    exec_pkg::byte_idx_t  alu_byte_idx;
    rv_isa_pkg::word_t    alu_wr_mem_data;

    // Head of the issue queue moves into the result queue in the same edge
    assign xfer = iq_valid && rq_ready;

    issue_queue #(.DEPTH(IQ_DEPTH)) i_issue_queue (
        .clk_i, .reset_i, .op_valid_i, .op_pc_i, .op_inst_i, .op1_i, .op2_i,
        .op1_jump_i, .op2_jump_i, .op_store_data_i,
        .pop_i        (xfer),
        .valid_o      (iq_valid),
        .pc_o         (iq_pc),
        .inst_o       (iq_inst),
        .op1_o        (iq_op1),
        .op2_o        (iq_op2),
        .op1_jump_o   (iq_op1_jump),
        .op2_jump_o   (iq_op2_jump),
        .store_data_o (iq_store_data),
        .op_credit_o
    );

    alu i_alu (
        .pc_i          (iq_pc),
        .inst_i        (iq_inst),
        .op1_i         (iq_op1),
        .op2_i         (iq_op2),
        .op1_jump_i    (iq_op1_jump),
        .op2_jump_i    (iq_op2_jump),
        .store_data_i  (iq_store_data),
        .reg_wdata_o   (alu_reg_wdata),
        .wr_reg_en_o   (alu_wr_reg_en),
        .wr_reg_idx_o  (alu_wr_reg_idx),
        .jump_o        (alu_jump),
        .jump_addr_o   (alu_jump_addr),
        .pc_o          (alu_pc),
        .load_o        (alu_load),
        .wr_mem_en_o   (alu_wr_mem_en),
        .mem_addr_o    (alu_mem_addr),
        .byte_idx_o    (alu_byte_idx),
        .wr_mem_data_o (alu_wr_mem_data)
    );

    result_queue #(.DEPTH(RQ_DEPTH), .CREDITS(RES_CREDITS)) i_result_queue (
        .clk_i, .reset_i,
        .push_i        (xfer),
        .reg_wdata_i   (alu_reg_wdata),
        .wr_reg_en_i   (alu_wr_reg_en),
        .wr_reg_idx_i  (alu_wr_reg_idx),
        .jump_i        (alu_jump),
        .jump_addr_i   (alu_jump_addr),
        .pc_i          (alu_pc),
        .load_i        (alu_load),
        .wr_mem_en_i   (alu_wr_mem_en),
        .mem_addr_i    (alu_mem_addr),
        .byte_idx_i    (alu_byte_idx),
        .wr_mem_data_i (alu_wr_mem_data),
        .ready_o       (rq_ready),
        .res_valid_o, .res_reg_wdata_o, .res_wr_reg_en_o, .res_wr_reg_idx_o,
        .res_jump_o, .res_jump_addr_o, .res_pc_o, .res_load_o, .res_wr_mem_en_o,
        .res_mem_addr_o, .res_byte_idx_o, .res_wr_mem_data_o, .res_credit_i
    );

endmodule

// ==== verilog/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue #(
    parameter int DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              op_valid_i,
    input  rv_isa_pkg::word_t op_pc_i,
    input  rv_isa_pkg::inst_t op_inst_i,
    input  rv_isa_pkg::word_t op1_i,
    input  rv_isa_pkg::word_t op2_i,
    input  rv_isa_pkg::word_t op1_jump_i,
    input  rv_isa_pkg::word_t op2_jump_i,
    input  rv_isa_pkg::word_t op_store_data_i,
    input  logic              pop_i,
    output logic              valid_o,
    output rv_isa_pkg::word_t pc_o,
    output rv_isa_pkg::inst_t inst_o,
    output rv_isa_pkg::word_t op1_o,
    output rv_isa_pkg::word_t op2_o,
    output rv_isa_pkg::word_t op1_jump_o,
    output rv_isa_pkg::word_t op2_jump_o,
    output rv_isa_pkg::word_t store_data_o,
    output logic              op_credit_o
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int ENTRY_W = 6 * $bits(rv_isa_pkg::word_t) + $bits(rv_isa_pkg::inst_t);

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    exec_pkg::credit_t  fill_cnt;

    assign valid_o = (fill_cnt != '0);

    assign {pc_o, inst_o, op1_o, op2_o, op1_jump_o, op2_jump_o, store_data_o} = mem[rd_ptr];

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (op_valid_i) begin
            mem[wr_ptr] <= {op_pc_i, op_inst_i, op1_i, op2_i,
                            op1_jump_i, op2_jump_i, op_store_data_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill_cnt    <= '0;
            op_credit_o <= 1'b0;
        end else begin
            // One credit goes back upstream per popped entry
            op_credit_o <= pop_i;
            if (op_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (op_valid_i && !pop_i) begin
                fill_cnt <= fill_cnt + 1'b1;
            end else if (!op_valid_i && pop_i) begin
                fill_cnt <= fill_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/result_queue.sv ====
`timescale 1ns/1ps

module result_queue #(
    parameter int DEPTH   = 4,
    parameter int CREDITS = 2
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 push_i,
    input  rv_isa_pkg::word_t    reg_wdata_i,
    input  logic                 wr_reg_en_i,
    input  rv_isa_pkg::reg_idx_t wr_reg_idx_i,
    input  logic                 jump_i,
    input  rv_isa_pkg::word_t    jump_addr_i,
    input  rv_isa_pkg::word_t    pc_i,
    input  logic                 load_i,
    input  logic                 wr_mem_en_i,
    input  rv_isa_pkg::word_t    mem_addr_i,
    input  exec_pkg::byte_idx_t  byte_idx_i,
    input  rv_isa_pkg::word_t    wr_mem_data_i,
    output logic                 ready_o,
    output logic                 res_valid_o,
    output rv_isa_pkg::word_t    res_reg_wdata_o,
    output logic                 res_wr_reg_en_o,
    output rv_isa_pkg::reg_idx_t res_wr_reg_idx_o,
    output logic                 res_jump_o,
    output rv_isa_pkg::word_t    res_jump_addr_o,
    output rv_isa_pkg::word_t    res_pc_o,
    output logic                 res_load_o,
    output logic                 res_wr_mem_en_o,
    output rv_isa_pkg::word_t    res_mem_addr_o,
    output exec_pkg::byte_idx_t  res_byte_idx_o,
    output rv_isa_pkg::word_t    res_wr_mem_data_o,
    input  logic                 res_credit_i
);

    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int ENTRY_W = 5 * $bits(rv_isa_pkg::word_t) + $bits(rv_isa_pkg::reg_idx_t) +
                             $bits(exec_pkg::byte_idx_t) + 4;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    exec_pkg::credit_t  fill_cnt;
    exec_pkg::credit_t  credit_cnt;

    assign ready_o     = (fill_cnt != exec_pkg::credit_t'(DEPTH));
    // Head entry goes out whenever a downstream credit is held
    assign res_valid_o = (fill_cnt != '0) && (credit_cnt != '0);

    assign {res_reg_wdata_o, res_wr_reg_en_o, res_wr_reg_idx_o, res_jump_o, res_jump_addr_o,
            res_pc_o, res_load_o, res_wr_mem_en_o, res_mem_addr_o, res_byte_idx_o,
            res_wr_mem_data_o} = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= {reg_wdata_i, wr_reg_en_i, wr_reg_idx_i, jump_i, jump_addr_i,
                            pc_i, load_i, wr_mem_en_i, mem_addr_i, byte_idx_i,
                            wr_mem_data_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_cnt   <= '0;
            credit_cnt <= exec_pkg::credit_t'(CREDITS);
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (res_valid_o) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_i && !res_valid_o) begin
                fill_cnt <= fill_cnt + 1'b1;
            end else if (!push_i && res_valid_o) begin
                fill_cnt <= fill_cnt - 1'b1;
            end
            if (res_credit_i && !res_valid_o) begin
                credit_cnt <= credit_cnt + 1'b1;
            end else if (!res_credit_i && res_valid_o) begin
                credit_cnt <= credit_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_NOP    = 7'b0000001;

    // Arithmetic, shared by OP_IMM and OP
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // M extension, multiplies only
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    // Branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage
